/* hw/fsync_pkg.sv */
/*
 * Fractal sync control core package.
 * Field widths, request kind and request/response formats.
 */
`default_nettype none

package fsync_pkg;

  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned AGGR_WIDTH = 4;
  localparam int unsigned LVL_WIDTH  = 3;
  localparam int unsigned N_PORTS    = 2;  // Fixed by the pairing logic.

  // Where a barrier completes.
  typedef enum logic {
    KIND_ROOT = 1'b0,  // At this node.
    KIND_FWD  = 1'b1   // At the parent.
  } sync_kind_e;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [AGGR_WIDTH-1:0] aggr;
  } sync_req_t;

  typedef struct packed {
    logic                 wake;
    logic                 error;
    logic [LVL_WIDTH-1:0] lvl;
    logic [ID_WIDTH-1:0]  id;
  } sync_rsp_t;

endpackage

`default_nettype wire

/* hw/fsync_rf_if.sv */
/*
 * Port controller to register file handshake, resolved within one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface fsync_rf_if;

  logic                             check;     // Request valid this cycle.
  fsync_pkg::sync_kind_e            kind;
  logic [fsync_pkg::ID_WIDTH-1:0]   id;
  logic                             complete;  // Barrier completes for this port.
  logic                             id_err;
  logic                             bypass;    // Both ports hit the same bit.

  modport ctrl (
    output check, kind, id,
    input  complete, id_err, bypass
  );

  modport rf (
    input  check, kind, id,
    output complete, id_err, bypass
  );

endinterface

`default_nettype wire

/* hw/fsync_fifo.sv */
/*
 * Synchronous circular FIFO with empty and full flags, head on elem_o.
 */
`timescale 1ns/1ps
`default_nettype none

module fsync_fifo #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter type         elem_t     = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  elem_t elem_i,
  input  logic  pop_i,
  output elem_t elem_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  elem_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr, rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push, do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(FIFO_DEPTH));
  assign do_push = push_i && !full_o;   // Dropped when full.
  assign do_pop  = pop_i && !empty_o;
  assign elem_o  = mem[rd_ptr];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr] <= elem_i;
  end

endmodule

`default_nettype wire

/* hw/fsync_port_queues.sv */
/*
 * Local response and remote request queues of one port,
 * flags a push into a full or a pop from an empty queue.
 */
`timescale 1ns/1ps
`default_nettype none

module fsync_port_queues #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_local_i,
  input  fsync_pkg::sync_rsp_t local_rsp_i,
  input  logic                 local_pop_i,
  output logic                 local_empty_o,
  output fsync_pkg::sync_rsp_t local_rsp_o,
  input  logic                 push_remote_i,
  input  fsync_pkg::sync_req_t remote_req_i,
  input  logic                 remote_pop_i,
  output logic                 remote_empty_o,
  output fsync_pkg::sync_req_t remote_req_o,
  output logic                 detected_error_o
);

  logic local_full, remote_full;

  fsync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .elem_t(fsync_pkg::sync_rsp_t)) i_local_fifo (
    .clk_i, .rst_ni,
    .push_i(push_local_i), .elem_i(local_rsp_i), .pop_i(local_pop_i),
    .elem_o(local_rsp_o), .empty_o(local_empty_o), .full_o(local_full)
  );

  fsync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .elem_t(fsync_pkg::sync_req_t)) i_remote_fifo (
    .clk_i, .rst_ni,
    .push_i(push_remote_i), .elem_i(remote_req_i), .pop_i(remote_pop_i),
    .elem_o(remote_req_o), .empty_o(remote_empty_o), .full_o(remote_full)
  );

  // Misuse of either queue, same cycle.
  assign detected_error_o = (push_local_i && local_full) || (local_pop_i && local_empty_o) ||
                            (push_remote_i && remote_full) || (remote_pop_i && remote_empty_o);

endmodule

`default_nettype wire

/* hw/fsync_port_ctrl.sv */
/*
 * Per-port request decode: level encoding, push decisions,
 * local response and forwarded request.
 */
`timescale 1ns/1ps
`default_nettype none

module fsync_port_ctrl #(
  parameter int unsigned PORT_IDX   = 0,
  parameter int unsigned LVL_OFFSET = 1
) (
  input  logic                               check_i,
  input  logic [fsync_pkg::ID_WIDTH-1:0]     id_i,
  input  logic [fsync_pkg::AGGR_WIDTH-1:0]   aggr_i,
  input  logic                               root_i,
  fsync_rf_if.ctrl                           rf,
  output logic                               push_local_o,
  output fsync_pkg::sync_rsp_t               local_rsp_o,
  output logic                               push_remote_o,
  output fsync_pkg::sync_req_t               remote_req_o
);

  fsync_pkg::sync_kind_e                kind;
  logic [fsync_pkg::LVL_WIDTH-1:0]      lvl;
  logic                                 skip_fwd;

  assign kind = root_i ? fsync_pkg::KIND_ROOT : fsync_pkg::KIND_FWD;

  assign rf.check = check_i;
  assign rf.kind  = kind;
  assign rf.id    = id_i;

  // Highest set bit wins, zero mask gives level 0.
  always_comb begin
    lvl = '0;
    for (int i = 0; i < fsync_pkg::AGGR_WIDTH; i++) begin
      if (aggr_i[i]) lvl = fsync_pkg::LVL_WIDTH'(i + LVL_OFFSET);
    end
  end

  // Only port 0 forwards a bypassed barrier.
  assign skip_fwd = (PORT_IDX != 0) && rf.bypass;

  assign push_local_o  = (rf.complete && kind == fsync_pkg::KIND_ROOT) || rf.id_err;
  assign push_remote_o = rf.complete && kind == fsync_pkg::KIND_FWD && !skip_fwd;

  assign local_rsp_o.wake  = 1'b1;
  assign local_rsp_o.error = rf.id_err;
  assign local_rsp_o.lvl   = lvl;
  assign local_rsp_o.id    = id_i;

  assign remote_req_o.id   = id_i;
  assign remote_req_o.aggr = aggr_i >> 1;  // One level up.

endmodule

`default_nettype wire

/* hw/fsync_sync_rf.sv */
/*
 * Directly mapped sync register file. One pending bit per id and kind,
 * pairs the two ports and bypasses same-cycle arrivals.
 */
`timescale 1ns/1ps
`default_nettype none

module fsync_sync_rf #(
  parameter int unsigned N_REGS = 12
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  fsync_rf_if.rf port0,
  fsync_rf_if.rf port1
);

  localparam int unsigned NP = fsync_pkg::N_PORTS;

  logic [N_REGS-1:0]              root_q, root_d;
  logic [N_REGS-1:0]              fwd_q, fwd_d;
  logic [NP-1:0]                  chk;
  logic [NP-1:0]                  vld;
  logic [NP-1:0]                  is_fwd;
  logic [NP-1:0]                  pend;
  logic [NP-1:0]                  hit;
  logic [fsync_pkg::ID_WIDTH-1:0] idx [NP];
  logic                           byp;

  assign chk[0]    = port0.check;
  assign chk[1]    = port1.check;
  assign idx[0]    = port0.id;
  assign idx[1]    = port1.id;
  assign is_fwd[0] = (port0.kind == fsync_pkg::KIND_FWD);
  assign is_fwd[1] = (port1.kind == fsync_pkg::KIND_FWD);

  for (genvar p = 0; p < NP; p++) begin : gen_lookup
    assign vld[p]  = (idx[p] < N_REGS);
    assign pend[p] = vld[p] && (is_fwd[p] ? fwd_q[idx[p]] : root_q[idx[p]]);
    assign hit[p]  = chk[p] && vld[p] && (byp || pend[p]);
  end

  // Same valid id, same kind, same cycle.
  assign byp = &chk && &vld && (idx[0] == idx[1]) && (is_fwd[0] == is_fwd[1]);

  // Present clears, absent sets, so a flip. Bypass leaves the bit alone.
  always_comb begin
    root_d = root_q;
    fwd_d  = fwd_q;
    for (int p = 0; p < NP; p++) begin
      if (chk[p] && vld[p] && !byp) begin
        if (is_fwd[p]) fwd_d[idx[p]] = !fwd_q[idx[p]];
        else           root_d[idx[p]] = !root_q[idx[p]];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      root_q <= '0;
      fwd_q  <= '0;
    end else begin
      root_q <= root_d;
      fwd_q  <= fwd_d;
    end
  end

  assign port0.complete = hit[0];
  assign port1.complete = hit[1];
  assign port0.id_err   = chk[0] && !vld[0];
  assign port1.id_err   = chk[1] && !vld[1];
  assign port0.bypass   = byp;
  assign port1.bypass   = byp;

endmodule

`default_nettype wire

/* hw/fsync_cc_top.sv */
/*
 * Fractal sync control core, 1D node with two RX ports.
 */
`timescale 1ns/1ps
`default_nettype none

module fsync_cc_top #(
  parameter int unsigned N_REGS     = 12,
  parameter int unsigned LVL_OFFSET = 1,
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             check_i        [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::ID_WIDTH-1:0]   id_i           [fsync_pkg::N_PORTS],
  input  logic [fsync_pkg::AGGR_WIDTH-1:0] aggr_i         [fsync_pkg::N_PORTS],
  input  logic                             root_i         [fsync_pkg::N_PORTS],

  output logic                             local_empty_o  [fsync_pkg::N_PORTS],
  output fsync_pkg::sync_rsp_t             local_rsp_o    [fsync_pkg::N_PORTS],
  input  logic                             local_pop_i    [fsync_pkg::N_PORTS],

  output logic                             remote_empty_o [fsync_pkg::N_PORTS],
  output logic [fsync_pkg::ID_WIDTH-1:0]   remote_id_o    [fsync_pkg::N_PORTS],
  output logic [fsync_pkg::AGGR_WIDTH-1:0] remote_aggr_o  [fsync_pkg::N_PORTS],
  input  logic                             remote_pop_i   [fsync_pkg::N_PORTS],

  output logic                             detected_error_o [fsync_pkg::N_PORTS]
);

  logic                 push_local  [fsync_pkg::N_PORTS];
  logic                 push_remote [fsync_pkg::N_PORTS];
  fsync_pkg::sync_rsp_t local_rsp   [fsync_pkg::N_PORTS];
  fsync_pkg::sync_req_t fwd_req     [fsync_pkg::N_PORTS];  // Into the remote FIFO.
  fsync_pkg::sync_req_t remote_head [fsync_pkg::N_PORTS];

  fsync_rf_if rf_if [fsync_pkg::N_PORTS] ();

  fsync_sync_rf #(.N_REGS(N_REGS)) i_sync_rf (
    .clk_i, .rst_ni,
    .port0(rf_if[0]),
    .port1(rf_if[1])
  );

  for (genvar p = 0; p < fsync_pkg::N_PORTS; p++) begin : gen_port
    fsync_port_ctrl #(.PORT_IDX(p), .LVL_OFFSET(LVL_OFFSET)) i_ctrl (
      .check_i(check_i[p]), .id_i(id_i[p]), .aggr_i(aggr_i[p]), .root_i(root_i[p]),
      .rf(rf_if[p]),
      .push_local_o(push_local[p]), .local_rsp_o(local_rsp[p]),
      .push_remote_o(push_remote[p]), .remote_req_o(fwd_req[p])
    );

    fsync_port_queues #(.FIFO_DEPTH(FIFO_DEPTH)) i_queues (
      .clk_i, .rst_ni,
      .push_local_i(push_local[p]), .local_rsp_i(local_rsp[p]),
      .local_pop_i(local_pop_i[p]), .local_empty_o(local_empty_o[p]),
      .local_rsp_o(local_rsp_o[p]),
      .push_remote_i(push_remote[p]), .remote_req_i(fwd_req[p]),
      .remote_pop_i(remote_pop_i[p]), .remote_empty_o(remote_empty_o[p]),
      .remote_req_o(remote_head[p]),
      .detected_error_o(detected_error_o[p])
    );

    assign remote_id_o[p]   = remote_head[p].id;
    assign remote_aggr_o[p] = remote_head[p].aggr;
  end

endmodule

`default_nettype wire

/* tb/tb_fsync_cc.sv */
/*
 * Testbench for the fractal sync control core.
 * Replays one case row per cycle and checks queue heads, flags and errors.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fsync_cc;

  localparam int NP        = fsync_pkg::N_PORTS;
  localparam int N_REGS    = 12;
  localparam int NCOL      = 25;  // Test number, 6 inputs and 6 expected values per port.
  localparam int MAX_ROWS  = 40;
  localparam int RST_LIMIT = 20;

  logic                             clk_i = 1'b0;
  logic                             rst_ni;
  logic                             check_i          [NP];
  logic [fsync_pkg::ID_WIDTH-1:0]   id_i             [NP];
  logic [fsync_pkg::AGGR_WIDTH-1:0] aggr_i           [NP];
  logic                             root_i           [NP];
  logic                             local_pop_i      [NP];
  logic                             remote_pop_i     [NP];
  logic                             local_empty_o    [NP];
  fsync_pkg::sync_rsp_t             local_rsp_o      [NP];
  logic                             remote_empty_o   [NP];
  logic [fsync_pkg::ID_WIDTH-1:0]   remote_id_o      [NP];
  logic [fsync_pkg::AGGR_WIDTH-1:0] remote_aggr_o    [NP];
  logic                             detected_error_o [NP];

  logic [15:0]                    cases [MAX_ROWS*NCOL];
  logic [15:0]                    lcg_state = 16'd49912;
  logic [15:0]                    pick;
  logic [fsync_pkg::ID_WIDTH-1:0] gen_id;
  logic                           err_seen [NP];  // Error flag in the row's own cycle.
  int                             n_rows;
  int                             errors;
  int                             test_errs;
  int                             tests_run;
  int                             tests_bad;
  int                             wait_cycles;
  bit                             timed_out;

  fsync_cc_top #(.N_REGS(N_REGS), .LVL_OFFSET(1), .FIFO_DEPTH(2)) DUT (
    .clk_i, .rst_ni, .check_i, .id_i, .aggr_i, .root_i,
    .local_empty_o, .local_rsp_o, .local_pop_i,
    .remote_empty_o, .remote_id_o, .remote_aggr_o, .remote_pop_i,
    .detected_error_o
  );

  always #50 clk_i = ~clk_i;

  // Full period 16-bit LCG.
  function automatic logic [15:0] lcg_next(input logic [15:0] s);
    return s * 16'd5 + 16'd12345;
  endfunction

  function automatic bit queues_idle();
    return local_empty_o[0] && local_empty_o[1] && remote_empty_o[0] && remote_empty_o[1];
  endfunction

  task check_val(input string name, input logic [15:0] exp_v, input logic [15:0] act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %0t %s expected %0h got %0h", $time, name, exp_v, act_v);
      test_errs++;
    end
  endtask

  task drive_idle();
    for (int p = 0; p < NP; p++) begin
      check_i[p]      <= 1'b0;
      id_i[p]         <= '0;
      aggr_i[p]       <= '0;
      root_i[p]       <= 1'b0;
      local_pop_i[p]  <= 1'b0;
      remote_pop_i[p] <= 1'b0;
    end
  endtask

  task drive_row(input int r);
    int b;
    b = r * NCOL;
    // Test 5 draws a new id on each port 0 arrival.
    if (cases[b] == 5 && cases[b+1] == 1) begin
      lcg_state = lcg_next(lcg_state);
      pick      = (lcg_state >> 8) % 16'(N_REGS);
      gen_id    = pick[fsync_pkg::ID_WIDTH-1:0];
    end
    for (int p = 0; p < NP; p++) begin
      check_i[p]      <= cases[b+1+p*6][0];
      id_i[p]         <= (cases[b] == 5) ? gen_id : cases[b+2+p*6][3:0];
      aggr_i[p]       <= cases[b+3+p*6][3:0];
      root_i[p]       <= cases[b+4+p*6][0];
      local_pop_i[p]  <= cases[b+5+p*6][0];
      remote_pop_i[p] <= cases[b+6+p*6][0];
    end
  endtask

  // Heads only count when the queue should hold something.
  task check_row(input int r);
    int b;
    b = r * NCOL + 13;
    for (int p = 0; p < NP; p++) begin
      check_val($sformatf("local_empty_o[%0d]", p), cases[b+p*6], local_empty_o[p]);
      if (cases[b+p*6] == 0)
        check_val($sformatf("local_rsp_o[%0d]", p), cases[b+1+p*6], local_rsp_o[p]);
      check_val($sformatf("remote_empty_o[%0d]", p), cases[b+2+p*6], remote_empty_o[p]);
      if (cases[b+2+p*6] == 0) begin
        check_val($sformatf("remote_id_o[%0d]", p), cases[b+3+p*6], remote_id_o[p]);
        check_val($sformatf("remote_aggr_o[%0d]", p), cases[b+4+p*6], remote_aggr_o[p]);
      end
      check_val($sformatf("detected_error_o[%0d]", p), cases[b+5+p*6], err_seen[p]);
    end
  endtask

  task finish_test(input int num);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %0d ok", num);
    end else begin
      $display("test %0d: %0d mismatches", num, test_errs);
      tests_bad++;
    end
    errors += test_errs;
    test_errs = 0;
  endtask

  initial begin
    rst_ni = 1'b0;
    drive_idle();
    $readmemh("tb/fsync_cases.txt", cases);
    n_rows = 0;
    while (n_rows < MAX_ROWS && cases[n_rows*NCOL] != 0) n_rows++;  // Row 00 ends the list.
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait_cycles = 0;
    do begin
      @(negedge clk_i);
      wait_cycles++;
    end while (!(rst_ni && queues_idle()) && wait_cycles < RST_LIMIT);
    timed_out = !(rst_ni && queues_idle());
    if (timed_out) begin
      $display("timeout: queues not empty after reset release");
    end else if (n_rows == 0) begin
      $display("no cases loaded from tb/fsync_cases.txt");
      errors++;
    end else begin
      // Row i is driven at edge i and checked after edge i+1.
      for (int i = 0; i <= n_rows; i++) begin
        @(posedge clk_i);
        if (i < n_rows) drive_row(i);
        else drive_idle();
        @(negedge clk_i);
        if (i > 0) begin
          check_row(i - 1);
          if (i == n_rows || cases[i*NCOL] != cases[(i-1)*NCOL])
            finish_test(cases[(i-1)*NCOL]);
        end
        for (int p = 0; p < NP; p++) err_seen[p] = detected_error_o[p];
      end
    end
    $display("%0d tests run, %0d with mismatches, %0d mismatches in total",
             tests_run, tests_bad, errors);
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/fsync_cases.txt */
// test, then per port 0 and 1: check id aggr root local_pop remote_pop
// then expected per port 0 and 1: local_empty local_rsp remote_empty remote_id remote_aggr error
1  1 3 3 1 0 0  0 0 0 0 0 0  1 000 1 0 0 0  1 000 1 0 0 0
1  0 0 0 0 0 0  1 3 6 1 0 0  1 000 1 0 0 0  0 133 1 0 0 0
1  0 0 0 0 0 0  0 0 0 0 1 0  1 000 1 0 0 0  1 000 1 0 0 0
2  1 5 8 1 0 0  1 5 1 1 0 0  0 145 1 0 0 0  0 115 1 0 0 0
2  0 0 0 0 1 0  0 0 0 0 1 0  1 000 1 0 0 0  1 000 1 0 0 0
3  1 2 6 0 0 0  0 0 0 0 0 0  1 000 1 0 0 0  1 000 1 0 0 0
3  0 0 0 0 0 0  1 2 c 0 0 0  1 000 1 0 0 0  1 000 0 2 6 0
3  1 9 a 0 0 0  1 9 3 0 0 1  1 000 0 9 5 0  1 000 1 0 0 0
3  0 0 0 0 0 1  0 0 0 0 0 0  1 000 1 0 0 0  1 000 1 0 0 0
4  1 e 5 1 0 0  0 0 0 0 0 0  0 1be 1 0 0 0  1 000 1 0 0 0
4  0 0 0 0 1 0  1 4 2 1 0 0  1 000 1 0 0 0  1 000 1 0 0 0
4  1 4 0 1 0 0  0 0 0 0 0 0  0 104 1 0 0 0  1 000 1 0 0 0
4  0 0 0 0 1 0  0 0 0 0 0 0  1 000 1 0 0 0  1 000 1 0 0 0
5  1 0 1 1 0 0  0 0 0 0 0 0  1 000 1 0 0 0  1 000 1 0 0 0
5  0 0 0 0 0 0  1 0 f 1 0 0  1 000 1 0 0 0  0 143 1 0 0 0
5  1 0 2 1 0 0  0 0 0 0 1 0  1 000 1 0 0 0  1 000 1 0 0 0
5  0 0 0 0 0 0  1 0 4 1 0 0  1 000 1 0 0 0  0 137 1 0 0 0
5  1 0 8 1 0 0  0 0 0 0 1 0  1 000 1 0 0 0  1 000 1 0 0 0
5  0 0 0 0 0 0  1 0 1 1 0 0  1 000 1 0 0 0  0 119 1 0 0 0
5  0 0 0 0 0 0  0 0 0 0 1 0  1 000 1 0 0 0  1 000 1 0 0 0
6  0 0 0 0 1 0  0 0 0 0 0 1  1 000 1 0 0 1  1 000 1 0 0 1
6  1 1 1 1 0 0  1 1 2 1 0 0  0 111 1 0 0 0  0 121 1 0 0 0
6  1 6 4 1 0 0  1 6 8 1 0 0  0 111 1 0 0 0  0 121 1 0 0 0
6  1 8 f 1 0 0  1 8 f 1 0 0  0 111 1 0 0 1  0 121 1 0 0 1
6  0 0 0 0 1 0  0 0 0 0 1 0  0 136 1 0 0 0  0 146 1 0 0 0
6  0 0 0 0 1 0  0 0 0 0 1 0  1 000 1 0 0 0  1 000 1 0 0 0
00

/* sim.f */
hw/fsync_pkg.sv
hw/fsync_rf_if.sv
hw/fsync_fifo.sv
hw/fsync_port_queues.sv
hw/fsync_port_ctrl.sv
hw/fsync_sync_rf.sv
hw/fsync_cc_top.sv
tb/tb_fsync_cc.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message.
verilator --binary --timing -Wno-fatal --top-module tb_fsync_cc -f sim.f -o tb_fsync_cc &&
  out=$(./obj_dir/tb_fsync_cc) &&
  printf '%s\n' "$out" &&
  printf '%s\n' "$out" | grep -qx "all tests passed" ||
  exit 1
